//--- include/rv32i_cfg.svh
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// first fetch address out of reset
`define RV32I_RESET_PC 32'h0000_0000

// architectural integer registers
// x0 included
`define RV32I_NUM_REGS 32

`endif

//--- hdl/rv32i_types.sv
package rv32i_types;

// basic word and register index
typedef logic [31:0] rv32i_word;
typedef logic [4:0]  rv32i_reg;

// major opcodes of the supported subset
typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_br    = 7'b1100011
} rv32i_opcode_t;

// load widths
// bit 2 marks zero extension
typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
} load_funct3_t;

typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
} store_funct3_t;

typedef enum logic [2:0] {
    beq = 3'b000,
    bne = 3'b001
} branch_funct3_t;

// five ops need three bits
typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
} alu_ops;

typedef enum logic [2:0] {
    s_fetch,
    s_decode,
    s_execute,
    s_memory,
    s_writeback
} cpu_state_t;

typedef enum logic {
    alumux2_rs2,
    alumux2_imm
} alumux2_sel_t;

typedef enum logic [1:0] {
    wb_alu,
    wb_mdr,
    wb_uimm
} wbdatamux_sel_t;

typedef enum logic {
    pc_plus4,
    pc_branch
} pcmux_sel_t;

endpackage : rv32i_types

//--- hdl/raw_mem_if.sv
`timescale 1ns/1ns

// unaligned data channel between datapath/control and the aligner
interface raw_mem_if;

// byte address straight from rs1 + offset
rv32i_types::rv32i_word addr;
// store data still in the low lanes
rv32i_types::rv32i_word wdata;
// load data already extracted and extended
rv32i_types::rv32i_word rdata;
// access width and sign, from the instruction
logic [2:0] funct3;

// core side
// datapath drives addr and wdata, control drives funct3
modport core (
    output addr,
    output wdata,
    output funct3,
    input  rdata
);

// aligner side
modport align (
    input  addr,
    input  wdata,
    input  funct3,
    output rdata
);

endinterface : raw_mem_if

//--- hdl/control.sv
`timescale 1ns/1ns

module control (
    input  logic                          clk,
    input  logic                          reset,
    input  rv32i_types::rv32i_word        instruction,
    input  logic                          br_en,
    input  logic                          i_resp,
    input  logic                          d_resp,
    output logic                          i_read,
    output logic                          load_ir,
    output rv32i_types::alu_ops           aluop,
    output rv32i_types::alumux2_sel_t     alumux2_sel,
    output rv32i_types::branch_funct3_t   cmpop,
    output rv32i_types::wbdatamux_sel_t   wbdatamux_sel,
    output rv32i_types::pcmux_sel_t       pcmux_sel,
    output logic                          pc_load,
    output logic                          regfile_wb,
    output logic                          load_mdr,
    output logic                          d_read,
    output logic                          d_write,
    raw_mem_if.core                       mem
);

rv32i_types::cpu_state_t    state;
rv32i_types::cpu_state_t    next_state;
rv32i_types::rv32i_opcode_t opcode;
logic [2:0]                 funct3;
logic [6:0]                 funct7;
logic                       is_load;
logic                       is_store;
logic                       is_wb;

// instruction fields
assign opcode = rv32i_types::rv32i_opcode_t'(instruction[6:0]);
assign funct3 = instruction[14:12];
assign funct7 = instruction[31:25];

assign is_load  = (opcode == rv32i_types::op_load);
assign is_store = (opcode == rv32i_types::op_store);
// register writers that skip the memory state
assign is_wb    = (opcode == rv32i_types::op_lui) || (opcode == rv32i_types::op_imm) ||
                  (opcode == rv32i_types::op_reg);

// alu op from funct3, funct7[5] only matters for reg-reg sub
always_comb begin
    case (funct3)
        3'b000: begin
            if ((opcode == rv32i_types::op_reg) && funct7[5]) begin
                aluop = rv32i_types::alu_sub;
            end else begin
                aluop = rv32i_types::alu_add;
            end
        end
        3'b100:  aluop = rv32i_types::alu_xor;
        3'b110:  aluop = rv32i_types::alu_or;
        3'b111:  aluop = rv32i_types::alu_and;
        default: aluop = rv32i_types::alu_add;
    endcase
end

// operand b is rs2 only for reg-reg ops
assign alumux2_sel = (opcode == rv32i_types::op_reg) ? rv32i_types::alumux2_rs2
                                                     : rv32i_types::alumux2_imm;
assign cmpop = rv32i_types::branch_funct3_t'(funct3);

always_comb begin
    case (opcode)
        rv32i_types::op_lui:  wbdatamux_sel = rv32i_types::wb_uimm;
        rv32i_types::op_load: wbdatamux_sel = rv32i_types::wb_mdr;
        default:              wbdatamux_sel = rv32i_types::wb_alu;
    endcase
end

// taken branch picks the target, everything else steps by four
assign pcmux_sel = ((opcode == rv32i_types::op_br) && br_en) ? rv32i_types::pc_branch
                                                             : rv32i_types::pc_plus4;

// width and sign for the aligner
assign mem.funct3 = funct3;

always_ff @(posedge clk) begin
    if (reset) begin
        state <= rv32i_types::s_fetch;
    end else begin
        state <= next_state;
    end
end

// next state
// waits are held in fetch and memory
always_comb begin
    next_state = state;
    case (state)
        rv32i_types::s_fetch:     if (i_resp) next_state = rv32i_types::s_decode;
        rv32i_types::s_decode:    next_state = rv32i_types::s_execute;
        rv32i_types::s_execute: begin
            if (is_load || is_store) begin
                next_state = rv32i_types::s_memory;
            end else if (is_wb) begin
                next_state = rv32i_types::s_writeback;
            end else begin
                // branches and unknown opcodes
                next_state = rv32i_types::s_fetch;
            end
        end
        rv32i_types::s_memory: begin
            if (d_resp) begin
                next_state = is_load ? rv32i_types::s_writeback : rv32i_types::s_fetch;
            end
        end
        default:                  next_state = rv32i_types::s_fetch;
    endcase
end

// strobes, each only in its own state
assign i_read     = (state == rv32i_types::s_fetch);
assign load_ir    = i_read && i_resp;
assign d_read     = (state == rv32i_types::s_memory) && is_load;
assign d_write    = (state == rv32i_types::s_memory) && is_store;
assign load_mdr   = d_read && d_resp;
assign regfile_wb = (state == rv32i_types::s_writeback);

// pc moves once per instruction
assign pc_load = regfile_wb || (d_write && d_resp) ||
                 ((state == rv32i_types::s_execute) && !is_load && !is_store && !is_wb);

endmodule : control

//--- hdl/pc_counter.sv
`timescale 1ns/1ns
`include "rv32i_cfg.svh"

module pc_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pc_load,
    input  rv32i_types::pcmux_sel_t pcmux_sel,
    input  rv32i_types::rv32i_word  branch_target,
    output rv32i_types::rv32i_word  pc
);

// sequential successor
rv32i_types::rv32i_word pc_plus4_value;

assign pc_plus4_value = pc + 32'd4;

always_ff @(posedge clk) begin
    if (reset) begin
        pc <= `RV32I_RESET_PC;
    end else if (pc_load) begin
        // target only on a taken branch
        case (pcmux_sel)
            rv32i_types::pc_branch: pc <= branch_target;
            default:                pc <= pc_plus4_value;
        endcase
    end
end

endmodule : pc_counter

//--- hdl/datapath.sv
`timescale 1ns/1ns
`include "rv32i_cfg.svh"

module datapath (
    input  logic                          clk,
    input  logic                          reset,
    input  rv32i_types::rv32i_word        i_rdata,
    input  logic                          load_ir,
    input  rv32i_types::rv32i_word        pc,
    input  rv32i_types::alu_ops           aluop,
    input  rv32i_types::alumux2_sel_t     alumux2_sel,
    input  rv32i_types::branch_funct3_t   cmpop,
    input  rv32i_types::wbdatamux_sel_t   wbdatamux_sel,
    input  logic                          regfile_wb,
    input  logic                          load_mdr,
    output rv32i_types::rv32i_word        instruction,
    output logic                          br_en,
    output rv32i_types::rv32i_word        branch_target,
    raw_mem_if.core                       mem
);

rv32i_types::rv32i_word regs [`RV32I_NUM_REGS];
rv32i_types::rv32i_word mdr;
rv32i_types::rv32i_reg  rs1;
rv32i_types::rv32i_reg  rs2;
rv32i_types::rv32i_reg  rd;
rv32i_types::rv32i_word rs1_out;
rv32i_types::rv32i_word rs2_out;
rv32i_types::rv32i_word i_imm;
rv32i_types::rv32i_word s_imm;
rv32i_types::rv32i_word b_imm;
rv32i_types::rv32i_word u_imm;
rv32i_types::rv32i_word alu_b;
rv32i_types::rv32i_word alu_out;
rv32i_types::rv32i_word wb_data;

// instruction register, loaded at the end of fetch
always_ff @(posedge clk) begin
    if (reset) begin
        instruction <= '0;
    end else if (load_ir) begin
        instruction <= i_rdata;
    end
end

// mdr holds aligned load data until writeback
always_ff @(posedge clk) begin
    if (load_mdr) begin
        mdr <= mem.rdata;
    end
end

assign rs1 = instruction[19:15];
assign rs2 = instruction[24:20];
assign rd  = instruction[11:7];

// register file
// x0 never written and always reads zero
always_ff @(posedge clk) begin
    if (regfile_wb && (rd != '0)) begin
        regs[rd] <= wb_data;
    end
end

assign rs1_out = (rs1 == '0) ? '0 : regs[rs1];
assign rs2_out = (rs2 == '0) ? '0 : regs[rs2];

// immediates
assign i_imm = {{21{instruction[31]}}, instruction[30:20]};
assign s_imm = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
assign b_imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                instruction[11:8], 1'b0};
assign u_imm = {instruction[31:12], 12'h000};

assign alu_b = (alumux2_sel == rv32i_types::alumux2_rs2) ? rs2_out : i_imm;

always_comb begin
    case (aluop)
        rv32i_types::alu_sub: alu_out = rs1_out - alu_b;
        rv32i_types::alu_and: alu_out = rs1_out & alu_b;
        rv32i_types::alu_or:  alu_out = rs1_out | alu_b;
        rv32i_types::alu_xor: alu_out = rs1_out ^ alu_b;
        default:              alu_out = rs1_out + alu_b;
    endcase
end

// branch compare, only beq and bne
always_comb begin
    case (cmpop)
        rv32i_types::beq: br_en = (rs1_out == rs2_out);
        rv32i_types::bne: br_en = (rs1_out != rs2_out);
        default:          br_en = 1'b0;
    endcase
end

assign branch_target = pc + b_imm;

always_comb begin
    case (wbdatamux_sel)
        rv32i_types::wb_mdr:  wb_data = mdr;
        rv32i_types::wb_uimm: wb_data = u_imm;
        default:              wb_data = alu_out;
    endcase
end

// effective address uses the s-type split for stores
assign mem.addr  = rs1_out + ((instruction[6:0] == rv32i_types::op_store) ? s_imm : i_imm);
assign mem.wdata = rs2_out;

endmodule : datapath

//--- hdl/mem_align.sv
`timescale 1ns/1ns

module mem_align (
    raw_mem_if.align               mem,
    output rv32i_types::rv32i_word mem_addr,
    input  rv32i_types::rv32i_word mem_rdata,
    output rv32i_types::rv32i_word mem_wdata,
    output logic [3:0]             mem_byte_enable
);

// byte offset inside the word
logic [1:0]             offset;
// read data with the addressed lane moved to bit 0
rv32i_types::rv32i_word lane_rdata;

assign offset = mem.addr[1:0];

// word aligned address for the data port
assign mem_addr = {mem.addr[31:2], 2'b00};

// store data into its lane
// upper bytes outside the enables are don't care
assign mem_wdata = mem.wdata << {offset, 3'b000};

// enables from the store width
always_comb begin
    case (mem.funct3[1:0])
        2'b00:   mem_byte_enable = 4'b0001 << offset;
        2'b01:   mem_byte_enable = 4'b0011 << offset;
        default: mem_byte_enable = 4'b1111;
    endcase
end

assign lane_rdata = mem_rdata >> {offset, 3'b000};

// extract and extend by load width
always_comb begin
    case (rv32i_types::load_funct3_t'(mem.funct3))
        rv32i_types::lb:  mem.rdata = {{24{lane_rdata[7]}}, lane_rdata[7:0]};
        rv32i_types::lbu: mem.rdata = {24'h000000, lane_rdata[7:0]};
        rv32i_types::lh:  mem.rdata = {{16{lane_rdata[15]}}, lane_rdata[15:0]};
        rv32i_types::lhu: mem.rdata = {16'h0000, lane_rdata[15:0]};
        // lw takes the whole word as is
        default:          mem.rdata = mem_rdata;
    endcase
end

endmodule : mem_align

//--- hdl/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic                   clk,
    input  logic                   reset,

    // instruction port, aligned
    output rv32i_types::rv32i_word i_addr,
    input  rv32i_types::rv32i_word i_rdata,
    output logic                   i_read,
    input  logic                   i_resp,

    // data port, aligned
    output rv32i_types::rv32i_word d_addr,
    input  rv32i_types::rv32i_word d_rdata,
    output rv32i_types::rv32i_word d_wdata,
    output logic [3:0]             d_byte_enable,
    output logic                   d_read,
    output logic                   d_write,
    input  logic                   d_resp
);

// unaligned channel, datapath and control to aligner
raw_mem_if mem ();

// control to datapath
rv32i_types::alu_ops         aluop;
rv32i_types::alumux2_sel_t   alumux2_sel;
rv32i_types::branch_funct3_t cmpop;
rv32i_types::wbdatamux_sel_t wbdatamux_sel;
logic                        load_ir;
logic                        regfile_wb;
logic                        load_mdr;

// control to pc counter
rv32i_types::pcmux_sel_t     pcmux_sel;
logic                        pc_load;

// datapath back to control and pc
rv32i_types::rv32i_word      instruction;
rv32i_types::rv32i_word      branch_target;
logic                        br_en;

control control (
    .clk           (clk),
    .reset         (reset),
    .instruction   (instruction),
    .br_en         (br_en),
    .i_resp        (i_resp),
    .d_resp        (d_resp),
    .i_read        (i_read),
    .load_ir       (load_ir),
    .aluop         (aluop),
    .alumux2_sel   (alumux2_sel),
    .cmpop         (cmpop),
    .wbdatamux_sel (wbdatamux_sel),
    .pcmux_sel     (pcmux_sel),
    .pc_load       (pc_load),
    .regfile_wb    (regfile_wb),
    .load_mdr      (load_mdr),
    .d_read        (d_read),
    .d_write       (d_write),
    .mem           (mem.core)
);

// pc is the fetch address directly
pc_counter pc_counter (
    .clk           (clk),
    .reset         (reset),
    .pc_load       (pc_load),
    .pcmux_sel     (pcmux_sel),
    .branch_target (branch_target),
    .pc            (i_addr)
);

datapath datapath (
    .clk           (clk),
    .reset         (reset),
    .i_rdata       (i_rdata),
    .load_ir       (load_ir),
    .pc            (i_addr),
    .aluop         (aluop),
    .alumux2_sel   (alumux2_sel),
    .cmpop         (cmpop),
    .wbdatamux_sel (wbdatamux_sel),
    .regfile_wb    (regfile_wb),
    .load_mdr      (load_mdr),
    .instruction   (instruction),
    .br_en         (br_en),
    .branch_target (branch_target),
    .mem           (mem.core)
);

mem_align d_align (
    .mem             (mem.align),
    .mem_addr        (d_addr),
    .mem_rdata       (d_rdata),
    .mem_wdata       (d_wdata),
    .mem_byte_enable (d_byte_enable)
);

endmodule : cpu

//--- tb/tb_clock.sv
`timescale 1ns/1ns

// free running clock, 8 ns period
module tb_clock (
    output logic clk
);

initial begin
    clk = 1'b0;
end

always #4 clk = ~clk;

endmodule : tb_clock

//--- tb/cpu_sva.sv
`timescale 1ns/1ns

module cpu_sva (
    input logic                   clk,
    input logic                   reset,
    input rv32i_types::rv32i_word i_addr,
    input logic                   i_read,
    input logic                   d_read,
    input logic                   d_write
);

// one data access direction at a time
a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(d_read && d_write))
    else $error("d_read and d_write high together");

// fetch and data access never overlap
a_fetch_data_excl: assert property (@(posedge clk) disable iff (reset)
    !(i_read && (d_read || d_write)))
    else $error("i_read high during a data access");

a_iaddr_aligned: assert property (@(posedge clk) disable iff (reset) i_addr[1:0] == 2'b00)
    else $error("i_addr not word aligned");

// data strobes quiet coming out of reset
a_reset_quiet: assert property (@(posedge clk) reset |=> (!d_read && !d_write))
    else $error("data strobe high after reset");

endmodule : cpu_sva

bind cpu cpu_sva i_sva (
    .clk     (clk),
    .reset   (reset),
    .i_addr  (i_addr),
    .i_read  (i_read),
    .d_read  (d_read),
    .d_write (d_write)
);

//--- tb/cpu_tb.sv
`timescale 1ns/1ns
`include "rv32i_cfg.svh"

module cpu_tb #(
    parameter int SEED = 3334
);

// total words of the four programs for the watchdog
localparam int PROG_WORDS = 23 + 27 + 9 + 12;
localparam int LIMIT      = PROG_WORDS * 20 + 4 * 20;
localparam logic [31:0] MARKER = 32'h0000_03fc;

logic                   clk;
logic                   reset;
rv32i_types::rv32i_word i_addr;
rv32i_types::rv32i_word i_rdata;
logic                   i_read;
logic                   i_resp;
rv32i_types::rv32i_word d_addr;
rv32i_types::rv32i_word d_rdata;
rv32i_types::rv32i_word d_wdata;
logic [3:0]             d_byte_enable;
logic                   d_read;
logic                   d_write;
logic                   d_resp;

rv32i_types::rv32i_word imem [256];
rv32i_types::rv32i_word dmem [256];
rv32i_types::rv32i_word fetch_q [$];
rv32i_types::rv32i_word st_addr_q [$];
rv32i_types::rv32i_word st_data_q [$];
logic [3:0]             st_be_q [$];
integer                 seed;
int                     i_wait;
int                     d_wait;
int                     emit_ptr;
logic                   done;
logic                   reset_sampled;

tb_clock i_clock (.clk(clk));

cpu i_dut (
    .clk           (clk),
    .reset         (reset),
    .i_addr        (i_addr),
    .i_rdata       (i_rdata),
    .i_read        (i_read),
    .i_resp        (i_resp),
    .d_addr        (d_addr),
    .d_rdata       (d_rdata),
    .d_wdata       (d_wdata),
    .d_byte_enable (d_byte_enable),
    .d_read        (d_read),
    .d_write       (d_write),
    .d_resp        (d_resp)
);

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
endtask

task automatic check_word(input string name, input rv32i_types::rv32i_word got,
                          input rv32i_types::rv32i_word exp);
    if (got !== exp) begin
        report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
endtask

// instruction encoders
function automatic rv32i_types::rv32i_word enc_i(input logic [6:0] op, input logic [4:0] rd,
    input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic rv32i_types::rv32i_word enc_r(input logic [6:0] f7, input logic [4:0] rd,
    input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic rv32i_types::rv32i_word enc_s(input logic [2:0] f3, input logic [4:0] rs1,
    input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic rv32i_types::rv32i_word enc_b(input logic [2:0] f3, input logic [4:0] rs1,
    input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic rv32i_types::rv32i_word enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

// background pattern where every address bit matters
function automatic rv32i_types::rv32i_word fill_word(input logic [31:0] addr);
    return addr ^ 32'h5a3c_96e1 ^ {addr[15:0], ~addr[15:0]};
endfunction

// byte lanes of wdata replace old where enabled
function automatic rv32i_types::rv32i_word merge_word(input rv32i_types::rv32i_word old,
    input rv32i_types::rv32i_word wdata, input logic [3:0] be);
    rv32i_types::rv32i_word res;
    res = old;
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            res[8*b +: 8] = wdata[8*b +: 8];
        end
    end
    return res;
endfunction

task automatic emit(input rv32i_types::rv32i_word w);
    imem[emit_ptr] = w;
    emit_ptr = emit_ptr + 1;
endtask

// put the core in reset and wipe memories and logs
task automatic start_test();
    @(posedge clk);
    #1;
    reset = 1'b1;
    @(posedge clk);
    #2;
    for (int k = 0; k < 256; k++) begin
        imem[k] = '0;
        dmem[k] = fill_word(k * 4);
    end
    fetch_q.delete();
    st_addr_q.delete();
    st_data_q.delete();
    st_be_q.delete();
    done = 1'b0;
    emit_ptr = 0;
endtask

// release reset, check first fetch, run to the marker store
task automatic run_program();
    logic got_first;
    got_first = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    while (!got_first) begin
        @(negedge clk);
        check_bit("i_read", i_read, 1'b1);
        check_bit("d_read", d_read, 1'b0);
        check_bit("d_write", d_write, 1'b0);
        check_word("i_addr", i_addr, `RV32I_RESET_PC);
        got_first = i_resp;
    end
    while (!done) begin
        @(posedge clk);
    end
endtask

task automatic check_store(input int idx, input rv32i_types::rv32i_word addr,
    input rv32i_types::rv32i_word data, input logic [3:0] be);
    if (idx >= st_addr_q.size()) begin
        report_failure($sformatf("store %0d never happened", idx));
    end
    check_word("d_addr", st_addr_q[idx], addr);
    check_word("d_wdata", st_data_q[idx], data);
    check_be("d_byte_enable", st_be_q[idx], be);
endtask

task automatic test_alu();
    rv32i_types::rv32i_word r [12];
    start_test();
    r[0]  = '0;
    r[1]  = 32'h1234_5000;
    r[2]  = 32'h0000_0678;
    r[3]  = 32'hffff_fffb;
    r[4]  = r[1] + r[2];
    r[5]  = r[2] - r[3];
    r[6]  = r[1] & r[3];
    r[7]  = r[2] | r[3];
    r[8]  = r[1] ^ r[3];
    r[9]  = r[3] & 32'h0000_00f0;
    r[10] = r[2] | 32'hffff_ff00;
    r[11] = r[1] ^ 32'h0000_0555;
    emit(enc_u(5'd1, 20'h12345));
    emit(enc_i(rv32i_types::op_imm, 5'd2, 3'b000, 5'd0, 12'h678));
    emit(enc_i(rv32i_types::op_imm, 5'd3, 3'b000, 5'd0, 12'hffb));
    emit(enc_r(7'h00, 5'd4, 3'b000, 5'd1, 5'd2));
    emit(enc_r(7'h20, 5'd5, 3'b000, 5'd2, 5'd3));
    emit(enc_r(7'h00, 5'd6, 3'b111, 5'd1, 5'd3));
    emit(enc_r(7'h00, 5'd7, 3'b110, 5'd2, 5'd3));
    emit(enc_r(7'h00, 5'd8, 3'b100, 5'd1, 5'd3));
    emit(enc_i(rv32i_types::op_imm, 5'd9, 3'b111, 5'd3, 12'h0f0));
    emit(enc_i(rv32i_types::op_imm, 5'd10, 3'b110, 5'd2, 12'hf00));
    emit(enc_i(rv32i_types::op_imm, 5'd11, 3'b100, 5'd1, 12'h555));
    for (int k = 1; k < 12; k++) begin
        emit(enc_s(3'b010, 5'd0, 5'(k), 12'(12'h080 + 4 * k)));
    end
    emit(enc_s(3'b010, 5'd0, 5'd0, MARKER[11:0]));
    run_program();
    for (int k = 1; k < 12; k++) begin
        check_store(k - 1, 32'h80 + 4 * k, r[k], 4'hf);
        check_word("dmem", dmem[(32'h80 + 4 * k) >> 2], r[k]);
    end
endtask

task automatic test_loads();
    logic [2:0]             f3 [13];
    int                     off [13];
    rv32i_types::rv32i_word word;
    rv32i_types::rv32i_word lane;
    rv32i_types::rv32i_word exp;
    start_test();
    word = 32'h80f1_7f92;
    dmem[32'h40 >> 2] = word;
    f3 = '{3'd2, 3'd1, 3'd1, 3'd5, 3'd5, 3'd0, 3'd0, 3'd0, 3'd0, 3'd4, 3'd4, 3'd4, 3'd4};
    off = '{0, 0, 2, 0, 2, 0, 1, 2, 3, 0, 1, 2, 3};
    for (int k = 0; k < 13; k++) begin
        emit(enc_i(rv32i_types::op_load, 5'(k + 1), f3[k], 5'd0, 12'(12'h040 + off[k])));
    end
    for (int k = 0; k < 13; k++) begin
        emit(enc_s(3'b010, 5'd0, 5'(k + 1), 12'(12'h100 + 4 * k)));
    end
    emit(enc_s(3'b010, 5'd0, 5'd0, MARKER[11:0]));
    run_program();
    for (int k = 0; k < 13; k++) begin
        lane = word >> (8 * off[k]);
        case (f3[k])
            3'd0:    exp = {{24{lane[7]}}, lane[7:0]};
            3'd4:    exp = {24'h0, lane[7:0]};
            3'd1:    exp = {{16{lane[15]}}, lane[15:0]};
            3'd5:    exp = {16'h0, lane[15:0]};
            default: exp = word;
        endcase
        check_store(k, 32'h100 + 4 * k, exp, 4'hf);
    end
endtask

task automatic test_stores();
    rv32i_types::rv32i_word val;
    rv32i_types::rv32i_word addr [6];
    rv32i_types::rv32i_word aligned;
    logic [3:0]             be;
    int                     o;
    start_test();
    val  = 32'ha1b2_c3d4;
    addr = '{32'h200, 32'h205, 32'h20a, 32'h20f, 32'h210, 32'h216};
    emit(enc_u(5'd1, 20'ha1b2c));
    emit(enc_i(rv32i_types::op_imm, 5'd1, 3'b000, 5'd1, 12'h3d4));
    for (int k = 0; k < 6; k++) begin
        emit(enc_s((k < 4) ? 3'b000 : 3'b001, 5'd0, 5'd1, addr[k][11:0]));
    end
    emit(enc_s(3'b010, 5'd0, 5'd0, MARKER[11:0]));
    run_program();
    for (int k = 0; k < 6; k++) begin
        o = int'(addr[k][1:0]);
        aligned = {addr[k][31:2], 2'b00};
        be = ((k < 4) ? 4'b0001 : 4'b0011) << o;
        check_store(k, aligned, val << (8 * o), be);
        check_word("dmem", dmem[aligned >> 2],
                   merge_word(fill_word(aligned), val << (8 * o), be));
    end
endtask

task automatic test_branches();
    rv32i_types::rv32i_word path [10];
    start_test();
    path = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd20, 32'd28, 32'd32, 32'd36, 32'd40, 32'd44};
    emit(enc_i(rv32i_types::op_imm, 5'd1, 3'b000, 5'd0, 12'd5));
    emit(enc_i(rv32i_types::op_imm, 5'd2, 3'b000, 5'd0, 12'd5));
    emit(enc_i(rv32i_types::op_imm, 5'd3, 3'b000, 5'd0, 12'd7));
    // taken beq, taken bne, then both not taken
    emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
    emit(enc_s(3'b010, 5'd0, 5'd1, 12'h300));
    emit(enc_b(3'b001, 5'd1, 5'd3, 13'd8));
    emit(enc_s(3'b010, 5'd0, 5'd1, 12'h304));
    emit(enc_b(3'b000, 5'd1, 5'd3, 13'd8));
    emit(enc_s(3'b010, 5'd0, 5'd1, 12'h308));
    emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
    emit(enc_s(3'b010, 5'd0, 5'd1, 12'h30c));
    emit(enc_s(3'b010, 5'd0, 5'd0, MARKER[11:0]));
    run_program();
    if (fetch_q.size() < 10) begin
        report_failure("branch program fetched fewer instructions than expected");
    end
    for (int k = 0; k < 10; k++) begin
        check_word("i_addr", fetch_q[k], path[k]);
    end
    if (st_addr_q.size() != 2) begin
        report_failure("wrong number of marker stores in branch program");
    end
    check_store(0, 32'h308, 32'd5, 4'hf);
    check_store(1, 32'h30c, 32'd5, 4'hf);
endtask

// reset as the core saw it at the last rising edge
always @(posedge clk) begin
    reset_sampled = reset;
end

// instruction memory with 0 to 3 wait cycles
always begin
    @(posedge clk);
    #1;
    i_resp = 1'b0;
    if (!reset_sampled && i_read) begin
        if (i_wait == 0) begin
            i_rdata = imem[i_addr[9:2]];
            i_resp = 1'b1;
            fetch_q.push_back(i_addr);
            i_wait = $random(seed) & 3;
        end else begin
            i_wait = i_wait - 1;
        end
    end
end

// data memory honoring byte enables on writes
always begin
    @(posedge clk);
    #1;
    d_resp = 1'b0;
    if (!reset_sampled && (d_read || d_write)) begin
        if (d_wait == 0) begin
            d_resp = 1'b1;
            if (d_read) begin
                d_rdata = dmem[d_addr[9:2]];
            end else begin
                dmem[d_addr[9:2]] = merge_word(dmem[d_addr[9:2]], d_wdata, d_byte_enable);
                if (d_addr == MARKER) begin
                    done = 1'b1;
                end else begin
                    st_addr_q.push_back(d_addr);
                    st_data_q.push_back(d_wdata);
                    st_be_q.push_back(d_byte_enable);
                end
            end
            d_wait = $random(seed) & 3;
        end else begin
            d_wait = d_wait - 1;
        end
    end
end

// hang guard
initial begin
    repeat (LIMIT) @(posedge clk);
    report_failure("timeout, the core never reached the end of the tests");
end

initial begin
    seed = SEED;
    reset = 1'b1;
    i_rdata = '0;
    i_resp = 1'b0;
    d_rdata = '0;
    d_resp = 1'b0;
    i_wait = 0;
    d_wait = 0;
    done = 1'b0;
    emit_ptr = 0;
    test_alu();
    test_loads();
    test_stores();
    test_branches();
    $display("Test completed successfully");
    $finish;
end

endmodule : cpu_tb

//--- project.f
+incdir+include
hdl/rv32i_types.sv
hdl/raw_mem_if.sv
hdl/control.sv
hdl/pc_counter.sv
hdl/datapath.sv
hdl/mem_align.sv
hdl/cpu.sv
tb/tb_clock.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
BUILD_DIR ?= build
SEED      ?= 3334

VFLAGS = --binary --timing --assert -f project.f --top-module $(TOP) \
         -Mdir $(BUILD_DIR) -GSEED=$(SEED)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
